/* Bender.yml */
package:
  name: dc_avg_buffer

sources:
  - include_dirs:
      - include
    files:
      - design/dc_avg_pkg.sv
      - design/avg_wr_if.sv
      - design/page_buffer.sv
      - design/block_accumulator.sv
      - design/mb_control.sv
      - design/readout_sequencer.sv
      - design/dc_subtractor.sv
      - design/dc_avg_buffer.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/dc_avg_buffer_assertions.sv
      - tb/tb_dc_avg_buffer.sv

/* design/avg_wr_if.sv */
`timescale 1ns/1ns

interface avg_wr_if;
    import dc_avg_pkg::*;

    logic    we;   // single-cycle write strobe
    page_t   page; // page the averaged block was written to
    blk_t    blk;  // block number inside the macroblock
    sample_t avg;  // truncated average or zero

    modport src (
        output we, page, blk, avg
    );

    modport dst (
        input we, page, blk, avg
    );

endinterface

/* design/block_accumulator.sv */
`timescale 1ns/1ns
`include "dc_avg_consts.svh"

module block_accumulator (
    input  logic                xclk,
    input  logic                reset,
    input  logic                mb_start,
    input  dc_avg_pkg::page_t   wr_page,
    input  logic                subtract_en,
    input  logic                y_we,
    input  logic [7:0]          y_addr,
    input  dc_avg_pkg::sample_t y_data,
    input  logic                c_we,
    input  logic [6:0]          c_addr,
    input  dc_avg_pkg::sample_t c_data,
    avg_wr_if.src               avg_out,
    output logic                blk_done,
    output dc_avg_pkg::blk_t    done_blk
);
    import dc_avg_pkg::*;

    localparam int NBLK = `DC_Y_BLOCKS + `DC_C_BLOCKS;

    logic [NBLK-1:0] en_q;       // one-hot block of the registered sample
    logic [NBLK-1:0] fresh;      // next sample of this block restarts its sum
    logic [NBLK-1:0] hit;        // 64th sample of the block is being added
    sample_t         y_q, c_q;   // samples aligned with en_q
    page_t           page_q;
    acc_t            sum     [NBLK];
    acc_t            sum_nxt [NBLK];
    sample_t         avg_nxt [NBLK];
    pix_t            cnt     [NBLK];
    logic            y_hit, c_hit;
    blk_t            y_idx, c_idx;
    logic            we_q;
    blk_t            blk_q;
    page_t           avg_page;
    sample_t         avg_q;
    logic            c_pend;     // C block finished together with a Y block
    blk_t            pend_blk;
    sample_t         pend_avg;

    always_comb begin
        for (int i = 0; i < NBLK; i++) begin
            sum_nxt[i] = (fresh[i] ? acc_t'(0) : sum[i]) + acc_t'((i < `DC_Y_BLOCKS) ? y_q : c_q);
            hit[i]     = en_q[i] && !fresh[i] && (cnt[i] == pix_t'(`DC_BLK_PIXELS - 1));
            avg_nxt[i] = subtract_en ? sample_t'(sum_nxt[i] >>> `DC_AVG_SHIFT) : sample_t'(0);
        end
        y_hit = 1'b0;
        y_idx = '0;
        for (int i = 0; i < `DC_Y_BLOCKS; i++) begin
            if (hit[i]) begin
                y_hit = 1'b1;
                y_idx = blk_t'(i);
            end
        end
        c_hit = 1'b0;
        c_idx = blk_t'(`DC_Y_BLOCKS);
        for (int i = `DC_Y_BLOCKS; i < NBLK; i++) begin
            if (hit[i]) begin
                c_hit = 1'b1;
                c_idx = blk_t'(i);
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (reset) begin
            en_q   <= '0;
            fresh  <= '1; // first sample after reset starts every sum
            we_q   <= 1'b0;
            c_pend <= 1'b0;
        end else begin
            en_q <= '0;
            if (y_we) en_q[y_addr[7:6]] <= 1'b1;
            if (c_we) en_q[`DC_Y_BLOCKS + c_addr[6]] <= 1'b1;
            fresh  <= mb_start ? '1 : (fresh & ~en_q);
            we_q   <= y_hit || c_hit || c_pend;
            c_pend <= y_hit && c_hit; // Y goes first, C one cycle later
        end
        y_q    <= y_data;
        c_q    <= c_data;
        page_q <= wr_page;
        for (int i = 0; i < NBLK; i++) begin
            if (en_q[i]) begin
                sum[i] <= sum_nxt[i];
                cnt[i] <= fresh[i] ? pix_t'(1) : cnt[i] + 1'b1;
            end
        end
        if (y_hit) begin
            blk_q <= y_idx;
            avg_q <= avg_nxt[y_idx];
        end else if (c_hit) begin
            blk_q <= c_idx;
            avg_q <= avg_nxt[c_idx];
        end else begin
            blk_q <= pend_blk;
            avg_q <= pend_avg;
        end
        if (y_hit || c_hit) avg_page <= page_q;
        if (c_hit) begin
            pend_blk <= c_idx;
            pend_avg <= avg_nxt[c_idx]; // snapshot so a new macroblock cannot disturb it
        end
    end

    assign avg_out.we   = we_q;
    assign avg_out.page = avg_page;
    assign avg_out.blk  = blk_q;
    assign avg_out.avg  = avg_q;
    assign blk_done     = we_q;
    assign done_blk     = blk_q;

endmodule

/* design/dc_avg_buffer.sv */
`timescale 1ns/1ns

module dc_avg_buffer (
    input  logic                xclk,
    input  logic                reset,
    input  logic                mb_start,
    input  logic                mono,
    input  logic                subtract_dc_in,
    input  logic                first_mb_in,
    input  logic                last_mb_in,
    input  logic                y_we,
    input  logic [7:0]          y_addr,
    input  dc_avg_pkg::sample_t y_data,
    input  logic                c_we,
    input  logic [6:0]          c_addr,
    input  dc_avg_pkg::sample_t c_data,
    output dc_avg_pkg::diff_t   dout,
    output dc_avg_pkg::sample_t avr,
    output logic                dv,
    output logic                ds,
    output dc_avg_pkg::blk_t    tn,
    output logic                first,
    output logic                last,
    output logic                lastinmb
);
    import dc_avg_pkg::*;

    page_t      wr_page, rd_page, buf_page;
    logic       subtract_en, rd_start, rd_mono, rd_first, rd_last;
    logic       blk_done, c_sel;
    blk_t       done_blk;
    logic [7:0] buf_addr;     // read block and pixel
    sample_t    y_rd, c_rd;

    avg_wr_if avg_wr ();

    page_buffer #(.ADDR_W(8)) i_y_buf (
        .xclk    (xclk),
        .wr_page (wr_page),
        .wr_addr (y_addr),
        .wr_en   (y_we),
        .wr_data (y_data),
        .rd_page (buf_page),
        .rd_addr (buf_addr),
        .rd_data (y_rd)
    );

    page_buffer #(.ADDR_W(7)) i_c_buf (
        .xclk    (xclk),
        .wr_page (wr_page),
        .wr_addr (c_addr),
        .wr_en   (c_we),
        .wr_data (c_data),
        .rd_page (buf_page),
        .rd_addr (buf_addr[6:0]),
        .rd_data (c_rd)
    );

    block_accumulator i_block_accumulator (
        .xclk        (xclk),
        .reset       (reset),
        .mb_start    (mb_start),
        .wr_page     (wr_page),
        .subtract_en (subtract_en),
        .y_we        (y_we),
        .y_addr      (y_addr),
        .y_data      (y_data),
        .c_we        (c_we),
        .c_addr      (c_addr),
        .c_data      (c_data),
        .avg_out     (avg_wr.src),
        .blk_done    (blk_done),
        .done_blk    (done_blk)
    );

    mb_control i_mb_control (
        .xclk           (xclk),
        .reset          (reset),
        .mb_start       (mb_start),
        .mono           (mono),
        .subtract_dc_in (subtract_dc_in),
        .first_mb_in    (first_mb_in),
        .last_mb_in     (last_mb_in),
        .blk_done       (blk_done),
        .done_blk       (done_blk),
        .wr_page        (wr_page),
        .subtract_en    (subtract_en),
        .rd_start       (rd_start),
        .rd_page        (rd_page),
        .rd_mono        (rd_mono),
        .rd_first       (rd_first),
        .rd_last        (rd_last)
    );

    readout_sequencer i_readout_sequencer (
        .xclk     (xclk),
        .reset    (reset),
        .rd_start (rd_start),
        .rd_page  (rd_page),
        .rd_mono  (rd_mono),
        .rd_first (rd_first),
        .rd_last  (rd_last),
        .buf_page (buf_page),
        .buf_addr (buf_addr),
        .c_sel    (c_sel),
        .dv       (dv),
        .ds       (ds),
        .tn       (tn),
        .first    (first),
        .last     (last),
        .lastinmb (lastinmb)
    );

    dc_subtractor i_dc_subtractor (
        .xclk    (xclk),
        .reset   (reset),
        .avg_in  (avg_wr.dst),
        .rd_page (buf_page),
        .rd_blk  ({c_sel, buf_addr[7:6]}), // 4 and 5 are Cb and Cr
        .c_sel   (c_sel),
        .y_data  (y_rd),
        .c_data  (c_rd),
        .dout    (dout),
        .avr     (avr)
    );

endmodule

/* design/dc_avg_pkg.sv */
`include "dc_avg_consts.svh"

package dc_avg_pkg;

    typedef logic signed [`DC_SAMPLE_W-1:0] sample_t; // buffer sample
    typedef logic signed [`DC_DIFF_W-1:0]   diff_t;   // zero-mean output sample
    typedef logic signed [`DC_ACC_W-1:0]    acc_t;    // running block sum

    typedef logic [$clog2(`DC_BLK_PIXELS)-1:0] pix_t; // pixel inside a block

    // 0..3 Y, 4 Cb, 5 Cr
    typedef logic [2:0] blk_t;

    typedef logic page_t; // double-buffer page

    typedef enum logic {
        RD_IDLE,  // waiting for a complete page
        RD_BLOCK  // stepping through block pixels
    } rd_state_t;

endpackage

/* design/dc_subtractor.sv */
`timescale 1ns/1ns

module dc_subtractor (
    input  logic                xclk,
    input  logic                reset,
    avg_wr_if.dst               avg_in,
    input  dc_avg_pkg::page_t   rd_page,
    input  dc_avg_pkg::blk_t    rd_blk,
    input  logic                c_sel,
    input  dc_avg_pkg::sample_t y_data,
    input  dc_avg_pkg::sample_t c_data,
    output dc_avg_pkg::diff_t   dout,
    output dc_avg_pkg::sample_t avr
);
    import dc_avg_pkg::*;

    sample_t    avg_mem [16]; // {page, block}
    sample_t    avg_q;        // readback, one cycle after address
    sample_t    avg_qq;       // aligned with buffer data
    logic [1:0] c_sel_d;
    sample_t    smp;

    always_ff @(posedge xclk) begin
        if (avg_in.we) begin
            avg_mem[{avg_in.page, avg_in.blk}] <= avg_in.avg;
        end
        avg_q  <= avg_mem[{rd_page, rd_blk}];
        avg_qq <= avg_q;
        if (reset) begin
            c_sel_d <= '0;
        end else begin
            c_sel_d <= {c_sel_d[0], c_sel}; // follows the 2 cycle buffer read
        end
        dout <= diff_t'(smp) - diff_t'(avg_qq); // both sign-extended
        avr  <= avg_qq;
    end

    assign smp = c_sel_d[1] ? c_data : y_data;

endmodule

/* design/mb_control.sv */
`timescale 1ns/1ns
`include "dc_avg_consts.svh"

module mb_control (
    input  logic              xclk,
    input  logic              reset,
    input  logic              mb_start,
    input  logic              mono,
    input  logic              subtract_dc_in,
    input  logic              first_mb_in,
    input  logic              last_mb_in,
    input  logic              blk_done,
    input  dc_avg_pkg::blk_t  done_blk,
    output dc_avg_pkg::page_t wr_page,
    output logic              subtract_en,
    output logic              rd_start,
    output dc_avg_pkg::page_t rd_page,
    output logic              rd_mono,
    output logic              rd_first,
    output logic              rd_last
);
    import dc_avg_pkg::*;

    localparam int NBLK = `DC_Y_BLOCKS + `DC_C_BLOCKS;

    logic [1:0]      mono_q, sub_q, first_q, last_q; // options per page
    page_t           done_page;   // page whose blocks are being averaged
    logic [NBLK-1:0] done_mask;   // blocks of done_page already averaged
    logic [NBLK-1:0] mask_nxt;
    logic [NBLK-1:0] need_mask;   // blocks the layout has
    logic            mb_complete;

    assign subtract_en = sub_q[done_page];
    assign need_mask   = mono_q[done_page] ? NBLK'((1 << `DC_Y_BLOCKS) - 1) : '1;
    assign mask_nxt    = done_mask | (blk_done ? (NBLK'(1) << done_blk) : '0);
    assign mb_complete = blk_done && ((mask_nxt & need_mask) == need_mask);

    always_ff @(posedge xclk) begin
        if (reset) begin
            wr_page   <= 1'b0;
            done_page <= 1'b1; // first macroblock after reset lands in page 1
            done_mask <= '0;
            rd_start  <= 1'b0;
        end else begin
            rd_start <= mb_complete;
            if (mb_start) wr_page <= ~wr_page;
            if (mb_complete) begin
                done_mask <= '0;
                done_page <= ~done_page;
            end else begin
                done_mask <= mask_nxt;
            end
        end
        if (mb_start) begin // options go with the page being opened
            mono_q[~wr_page]  <= mono;
            sub_q[~wr_page]   <= subtract_dc_in;
            first_q[~wr_page] <= first_mb_in;
            last_q[~wr_page]  <= last_mb_in;
        end
        if (mb_complete) begin // held for the sequencer until the next page completes
            rd_page  <= done_page;
            rd_mono  <= mono_q[done_page];
            rd_first <= first_q[done_page];
            rd_last  <= last_q[done_page];
        end
    end

endmodule

/* design/page_buffer.sv */
`timescale 1ns/1ns

module page_buffer #(
    parameter int ADDR_W = 8 // 8 for Y, 7 for C
) (
    input  logic                 xclk,
    input  dc_avg_pkg::page_t    wr_page,
    input  logic [ADDR_W-1:0]    wr_addr,
    input  logic                 wr_en,
    input  dc_avg_pkg::sample_t  wr_data,
    input  dc_avg_pkg::page_t    rd_page,
    input  logic [ADDR_W-1:0]    rd_addr,
    output dc_avg_pkg::sample_t  rd_data
);
    import dc_avg_pkg::*;

    sample_t mem [2**(ADDR_W+1)]; // page is the address msb
    sample_t rd_q;                // ram latch stage

    always_ff @(posedge xclk) begin
        if (wr_en) begin
            mem[{wr_page, wr_addr}] <= wr_data;
        end
        rd_q    <= mem[{rd_page, rd_addr}]; // first read register
        rd_data <= rd_q;                    // output register of the block ram
    end

endmodule

/* design/readout_sequencer.sv */
`timescale 1ns/1ns
`include "dc_avg_consts.svh"

module readout_sequencer (
    input  logic              xclk,
    input  logic              reset,
    input  logic              rd_start,
    input  dc_avg_pkg::page_t rd_page,
    input  logic              rd_mono,
    input  logic              rd_first,
    input  logic              rd_last,
    output dc_avg_pkg::page_t buf_page,
    output logic [7:0]        buf_addr,
    output logic              c_sel,
    output logic              dv,
    output logic              ds,
    output dc_avg_pkg::blk_t  tn,
    output logic              first,
    output logic              last,
    output logic              lastinmb
);
    import dc_avg_pkg::*;

    localparam int DLY = 3; // buffer ram 2 plus subtractor 1

    rd_state_t           state;
    pix_t                pix;
    blk_t                blk;
    page_t               page_r;
    logic                mono_r, first_r, last_r;
    logic                pend;     // page completed during the current readout
    logic                active, last_pix, last_blk, go, launch;
    logic [7:0]          tag;      // dv ds lastinmb first last tn
    logic [DLY-1:0][7:0] pipe;

    assign active   = (state == RD_BLOCK);
    assign last_pix = (pix == pix_t'(`DC_BLK_PIXELS - 1));
    assign last_blk = (blk == (mono_r ? blk_t'(`DC_Y_BLOCKS - 1)
                                      : blk_t'(`DC_Y_BLOCKS + `DC_C_BLOCKS - 1)));
    assign go       = rd_start || pend;
    assign launch   = go && (!active || (last_pix && last_blk)); // back to back across pages

    always_ff @(posedge xclk) begin
        if (reset) begin
            state <= RD_IDLE;
            pix   <= '0;
            blk   <= '0;
            pend  <= 1'b0;
            pipe  <= '0;
        end else begin
            pipe <= {pipe[DLY-2:0], tag};
            case (state)
                RD_IDLE: begin
                    if (launch) begin
                        state <= RD_BLOCK;
                        pend  <= 1'b0;
                    end
                end
                RD_BLOCK: begin
                    pix <= pix + 1'b1; // wraps to 0 at block end
                    if (last_pix && last_blk) begin
                        blk  <= '0;
                        pend <= 1'b0;
                        if (!go) state <= RD_IDLE;
                    end else begin
                        if (last_pix) blk <= blk + 1'b1;
                        if (rd_start) pend <= 1'b1;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
        if (launch) begin
            page_r  <= rd_page;
            mono_r  <= rd_mono;
            first_r <= rd_first;
            last_r  <= rd_last;
        end
    end

    assign tag = {active, active && (pix == '0), active && last_blk,
                  active && first_r, active && last_r, blk};

    assign buf_page = page_r;
    assign buf_addr = {blk[1:0], pix}; // Y block or Cb/Cr in bit 6
    assign c_sel    = blk[2];

    assign {dv, ds, lastinmb, first, last, tn} = pipe[DLY-1];

endmodule

/* files.f */
+incdir+include
design/dc_avg_pkg.sv
design/avg_wr_if.sv
design/page_buffer.sv
design/block_accumulator.sv
design/mb_control.sv
design/readout_sequencer.sv
design/dc_subtractor.sv
design/dc_avg_buffer.sv
tb/dc_avg_buffer_assertions.sv
tb/tb_dc_avg_buffer.sv

/* include/dc_avg_consts.svh */
`ifndef DC_AVG_CONSTS_SVH
`define DC_AVG_CONSTS_SVH

// sample and arithmetic widths
`define DC_SAMPLE_W    9   // signed buffer sample
`define DC_DIFF_W      10  // signed sample minus average
`define DC_ACC_W       15  // 64 samples of 9 bits

// block geometry
`define DC_BLK_PIXELS  64  // 8x8 block
`define DC_AVG_SHIFT   6   // log2 of samples per block
`define DC_Y_BLOCKS    4   // Y blocks per macroblock
`define DC_C_BLOCKS    2   // Cb and Cr

`endif

/* tb/dc_avg_buffer_assertions.sv */
`timescale 1ns/1ns

module dc_avg_buffer_assertions (
    input logic                  xclk,
    input logic                  reset,
    input logic                  dv,
    input logic                  ds,
    input dc_avg_pkg::blk_t      tn,
    input logic                  mono,  // layout latched at readout launch
    input dc_avg_pkg::rd_state_t state
);
    import dc_avg_pkg::*;

    logic [2:0] mono_d;       // layout aligned with the output pipe
    int         fail_cnt = 0; // failed assertions so far

    always_ff @(posedge xclk) begin
        mono_d <= {mono_d[1:0], mono};
    end

    a_ds_dv: assert property (@(posedge xclk) disable iff (reset) ds |-> dv)
        else begin
            $error("ds without dv");
            fail_cnt++;
        end

    // 64 dv cycles, then a new ds or dv low
    a_blk_len: assert property (@(posedge xclk) disable iff (reset)
        ds |-> ##1 (dv && !ds) [*63] ##1 (!dv || ds))
        else begin
            $error("block is not 64 dv cycles long");
            fail_cnt++;
        end

    a_tn: assert property (@(posedge xclk) disable iff (reset)
        dv |-> (tn < (mono_d[2] ? 3'd4 : 3'd6)))
        else begin
            $error("tn out of range for the layout");
            fail_cnt++;
        end

    a_reset: assert property (@(posedge xclk) reset |=> (!dv && !ds && state == RD_IDLE))
        else begin
            $error("output strobe or readout active in reset");
            fail_cnt++;
        end

endmodule

bind readout_sequencer dc_avg_buffer_assertions i_dc_avg_buffer_assertions (
    .xclk (xclk), .reset (reset), .dv (dv), .ds (ds), .tn (tn),
    .mono (mono_r), .state (state)
);

/* tb/tb_dc_avg_buffer.sv */
`timescale 1ns/1ns
`include "dc_avg_consts.svh"

module tb_dc_avg_buffer;
    import dc_avg_pkg::*;

    localparam int NROWS  = 9;
    localparam int MB_SMP = 6 * `DC_BLK_PIXELS; // 4 Y + Cb + Cr
    localparam int LIMIT  = NROWS * 800 + 1000;  // cycles before the run is declared hung

    // mono, subtract, first, last, base, spread
    int tbl [NROWS][6] = '{
        '{0, 1, 1, 0,    0, 100},  // colour, zero-mean removal
        '{1, 1, 0, 0,   40,  60},  // mono, written into the other page
        '{0, 0, 0, 0,  -30, 200},  // subtraction off
        '{1, 0, 0, 1,   10, 255},
        '{0, 1, 1, 0,  255,   0},  // every sample +255
        '{0, 1, 0, 1, -256,   0},  // every sample -256
        '{1, 1, 1, 1, -100, 150},
        '{0, 1, 0, 0,    0, 511},  // mostly clipped to both extremes
        '{0, 1, 0, 1,  100, 255}
    };

    logic       xclk, reset, mb_start, mono, subtract_dc_in, first_mb_in, last_mb_in;
    logic       y_we, c_we;
    logic [7:0] y_addr;
    logic [6:0] c_addr;
    sample_t    y_data, c_data, avr;
    diff_t      dout;
    logic       dv, ds, first, last, lastinmb;
    blk_t       tn;

    int smp [NROWS][MB_SMP]; // indexed by block * 64 + pixel
    int avg_exp [NROWS][6];  // floor averages per block
    int seed    = 32'h7c48;
    int errors  = 0;
    int cycles  = 0;
    int mb_done = 0;         // macroblocks fully read out
    int mb_err  = 0;
    int out_blk = 0;
    int out_pix = 0;

    dc_avg_buffer i_dc_avg_buffer (
        .xclk (xclk), .reset (reset), .mb_start (mb_start), .mono (mono),
        .subtract_dc_in (subtract_dc_in), .first_mb_in (first_mb_in), .last_mb_in (last_mb_in),
        .y_we (y_we), .y_addr (y_addr), .y_data (y_data),
        .c_we (c_we), .c_addr (c_addr), .c_data (c_data),
        .dout (dout), .avr (avr), .dv (dv), .ds (ds), .tn (tn),
        .first (first), .last (last), .lastinmb (lastinmb)
    );

    initial begin
        xclk = 1'b0;
        forever #4 xclk = ~xclk; // 8 ns period
    end

    function automatic int clip9(input int v);
        if (v > 255) return 255;
        if (v < -256) return -256;
        return v;
    endfunction

    function automatic int floor_avg(input int sum); // rounds toward minus infinity
        if (sum >= 0) return sum / `DC_BLK_PIXELS;
        return -((-sum + `DC_BLK_PIXELS - 1) / `DC_BLK_PIXELS);
    endfunction

    function automatic int blocks_of(input int r);
        return (tbl[r][0] != 0) ? 4 : 6;
    endfunction

    task automatic build_model();
        int sum;
        int v;
        for (int r = 0; r < NROWS; r++) begin
            for (int b = 0; b < 6; b++) begin
                sum = 0;
                for (int p = 0; p < `DC_BLK_PIXELS; p++) begin
                    v = clip9(tbl[r][4] + $random(seed) % (tbl[r][5] + 1));
                    smp[r][b * `DC_BLK_PIXELS + p] = v;
                    sum += v;
                end
                avg_exp[r][b] = floor_avg(sum);
            end
        end
    endtask

    task automatic write_mb(input int r);
        int a;
        @(posedge xclk);
        mb_start       <= 1'b1;
        mono           <= (tbl[r][0] != 0);
        subtract_dc_in <= (tbl[r][1] != 0);
        first_mb_in    <= (tbl[r][2] != 0);
        last_mb_in     <= (tbl[r][3] != 0);
        @(posedge xclk);
        mb_start <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            a = (r % 2 != 0) ? 255 - i : i; // odd rows fill Y backwards
            y_we   <= 1'b1;
            y_addr <= 8'(a);
            y_data <= sample_t'(smp[r][a]);
            if (tbl[r][0] == 0 && i < 128) begin // Cb then Cr alongside Y
                c_we   <= 1'b1;
                c_addr <= 7'(i);
                c_data <= sample_t'(smp[r][256 + i]);
            end else begin
                c_we <= 1'b0;
            end
            @(posedge xclk);
        end
        y_we <= 1'b0;
        c_we <= 1'b0;
    endtask

    task automatic check_field(input string name, input logic [9:0] got, input logic [9:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s mb %0d blk %0d pix %0d: got %h expected %h",
                     name, mb_done, out_blk, out_pix, got, exp);
            errors++;
            mb_err++;
        end
    endtask

    always @(posedge xclk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, only %0d of %0d macroblocks read out",
                     cycles, mb_done, NROWS);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(posedge xclk) begin : monitor
        int idx;
        int exp_d;
        int exp_a;
        if (reset) begin
            out_pix = 0;
        end else if (dv && mb_done >= NROWS) begin
            assert (!ds) else begin
                $display("extra block with tn %0d after the last macroblock", tn);
                errors++;
            end
        end else if (dv) begin
            if (ds) begin
                assert (out_pix == 0) else begin
                    $display("block %0d of macroblock %0d cut short after %0d samples",
                             out_blk, mb_done, out_pix);
                    errors++;
                    mb_err++;
                end
                out_pix = 0;
                check_field("tn", tn, 10'(out_blk)); // a skipped block shows up here
                check_field("first", first, 10'(tbl[mb_done][2]));
                check_field("last", last, 10'(tbl[mb_done][3]));
                check_field("lastinmb", lastinmb, 10'(out_blk == blocks_of(mb_done) - 1));
            end else begin
                assert (out_pix != 0) else begin
                    $display("dv rose without ds in macroblock %0d", mb_done);
                    errors++;
                    mb_err++;
                end
            end
            idx   = out_blk * `DC_BLK_PIXELS + out_pix;
            exp_a = (tbl[mb_done][1] != 0) ? avg_exp[mb_done][out_blk] : 0;
            exp_d = smp[mb_done][idx] - exp_a;
            check_field("dout", dout, 10'(exp_d));
            check_field("avr", avr, 10'(exp_a)); // sign-extended on both sides
            out_pix++;
            if (out_pix == `DC_BLK_PIXELS) begin
                out_pix = 0;
                out_blk++;
                if (out_blk == blocks_of(mb_done)) begin
                    $display("macroblock %0d %s subtract %0d: %0d blocks, %0d errors", mb_done,
                             (tbl[mb_done][0] != 0) ? "mono" : "colour", tbl[mb_done][1],
                             out_blk, mb_err);
                    mb_done++;
                    out_blk = 0;
                    mb_err  = 0;
                end
            end
        end else begin
            assert (out_pix == 0) else begin
                $display("dv fell after %0d samples of block %0d", out_pix, out_blk);
                errors++;
                mb_err++;
            end
            out_pix = 0;
        end
    end

    initial begin
        reset          = 1'b1;
        mb_start       = 1'b0;
        mono           = 1'b0;
        subtract_dc_in = 1'b0;
        first_mb_in    = 1'b0;
        last_mb_in     = 1'b0;
        y_we           = 1'b0;
        y_addr         = '0;
        y_data         = '0;
        c_we           = 1'b0;
        c_addr         = '0;
        c_data         = '0;
        build_model();
        repeat (4) @(posedge xclk);
        reset <= 1'b0;
        for (int r = 0; r < NROWS; r++) begin
            if (r >= 2) wait (mb_done >= r - 1); // page of row r-2 must be drained
            write_mb(r);
        end
        wait (mb_done == NROWS);
        repeat (20) @(posedge xclk); // room for a stray block to show
        errors += i_dc_avg_buffer.i_readout_sequencer.i_dc_avg_buffer_assertions.fail_cnt;
        $display("%0d macroblocks, %0d errors, %0d cycles", mb_done, errors, cycles);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
